/* design/hot_tracker_pkg.sv */
package hot_tracker_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int ADDR_SIZE  = 33;                    // cache-line address
  localparam int DATA_SIZE  = 22;                    // page number
  localparam int PAGE_SHIFT = ADDR_SIZE - DATA_SIZE; // line bits inside one page
  localparam int CNT_SIZE   = 13;                    // access counter, saturating
  localparam int CMD_WIDTH  = 4;                     // query command

  ////////////////////////////////////////////////////////////
  // limits and default sizes
  ////////////////////////////////////////////////////////////

  localparam int TOP_K           = 5; // larger commands are clamped to this
  localparam int DEF_NUM_ENTRY   = 8; // table entries per bank
  localparam int DEF_MIG_CREDITS = 2; // credits the consumer grants at reset

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [ADDR_SIZE-1:0] addr_t; // line address
  typedef logic [DATA_SIZE-1:0] page_t; // address >> PAGE_SHIFT
  typedef logic [CNT_SIZE-1:0]  cnt_t;  // all ones means saturated
  typedef logic [CMD_WIDTH-1:0] cmd_t;  // requested number of pages

endpackage

/* design/access_filter.sv */
`timescale 1ns/100ps

module access_filter (
  input  logic                  clk_400mhz,
  input  logic                  rstn,
  input  hot_tracker_pkg::addr_t araddr,
  input  logic                  arvalid,
  input  logic                  arready,
  input  hot_tracker_pkg::addr_t csr_addr_lb,
  input  hot_tracker_pkg::addr_t csr_addr_ub,
  output logic                  mem_chan_rd_en,
  output logic                  even_hit_en,
  output hot_tracker_pkg::page_t even_page,
  output logic                  odd_hit_en,
  output hot_tracker_pkg::page_t odd_page
);

  import hot_tracker_pkg::*;

  addr_t lb_r;      // window bounds, inclusive
  addr_t ub_r;
  page_t acc_page;
  logic  in_range;
  logic  accept;

  ////////////////////////////////////////////////////////////
  // bound registers
  ////////////////////////////////////////////////////////////

  // csr side is quasi-static, one flop stage is enough
  always_ff @(posedge clk_400mhz or negedge rstn) begin
    if (!rstn) begin
      lb_r <= '0;
      ub_r <= '0;
    end else begin
      lb_r <= csr_addr_lb;
      ub_r <= csr_addr_ub;
    end
  end

  ////////////////////////////////////////////////////////////
  // range test and bank steering
  ////////////////////////////////////////////////////////////

  assign in_range       = (araddr >= lb_r) && (araddr <= ub_r);
  assign accept         = arvalid & arready & in_range; // completed handshake in window
  assign mem_chan_rd_en = accept;

  assign acc_page = araddr[ADDR_SIZE-1:PAGE_SHIFT]; // drop line bits

  // lowest page bit picks the bank
  assign even_hit_en = accept & ~acc_page[0];
  assign odd_hit_en  = accept & acc_page[0];
  assign even_page   = acc_page;
  assign odd_page    = acc_page;

endmodule

/* design/hot_tracker_bank.sv */
`timescale 1ns/100ps

module hot_tracker_bank #(
  parameter  int NUM_ENTRY = hot_tracker_pkg::DEF_NUM_ENTRY,
  localparam int IDX_W     = $clog2(NUM_ENTRY)
) (
  input  logic                  clk_400mhz,
  input  logic                  rstn,
  input  logic                  hit_en,
  input  hot_tracker_pkg::page_t page,
  input  logic                  busy,
  input  logic                  clr_en,
  input  logic [IDX_W-1:0]      clr_idx,
  output logic                  max_valid,
  output hot_tracker_pkg::page_t max_page,
  output hot_tracker_pkg::cnt_t  max_cnt,
  output logic [IDX_W-1:0]      max_idx
);

  import hot_tracker_pkg::*;

  logic [NUM_ENTRY-1:0] valid;          // entry holds a tracked page
  page_t                page_tab [NUM_ENTRY];
  cnt_t                 cnt_tab  [NUM_ENTRY];

  logic                 upd_en;
  logic                 hit;
  logic [IDX_W-1:0]     hit_idx;
  logic                 has_free;
  logic [IDX_W-1:0]     free_idx;

  // table is frozen while a query walks it
  assign upd_en = hit_en & ~busy;

  ////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////

  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (!hit && valid[i] && (page_tab[i] == page)) begin
        hit     = 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
  end

  always_comb begin
    has_free = 1'b0;
    free_idx = '0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (!has_free && !valid[i]) begin // first free slot wins
        has_free = 1'b1;
        free_idx = IDX_W'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // table update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_400mhz or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else begin
      if (clr_en) begin
        valid[clr_idx] <= 1'b0; // entry handed to migration
      end
      if (upd_en && !hit && has_free) begin
        valid[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_400mhz) begin
    if (upd_en) begin
      if (hit) begin
        if (cnt_tab[hit_idx] != '1) begin
          cnt_tab[hit_idx] <= cnt_tab[hit_idx] + 1'b1;
        end
      end else if (has_free) begin
        page_tab[free_idx] <= page;
        cnt_tab[free_idx]  <= cnt_t'(1);
      end
      // full table and a miss, the access is simply dropped
    end
  end

  ////////////////////////////////////////////////////////////
  // hottest-entry search
  ////////////////////////////////////////////////////////////

  // strict compare keeps the lower index on a tie
  always_comb begin
    max_valid = 1'b0;
    max_page  = '0;
    max_cnt   = '0;
    max_idx   = '0;
    for (int i = 0; i < NUM_ENTRY; i++) begin
      if (valid[i] && (!max_valid || (cnt_tab[i] > max_cnt))) begin
        max_valid = 1'b1;
        max_page  = page_tab[i];
        max_cnt   = cnt_tab[i];
        max_idx   = IDX_W'(i);
      end
    end
  end

endmodule

/* design/mig_addr_selector.sv */
`timescale 1ns/100ps

module mig_addr_selector #(
  parameter  int NUM_ENTRY   = hot_tracker_pkg::DEF_NUM_ENTRY,
  parameter  int MIG_CREDITS = hot_tracker_pkg::DEF_MIG_CREDITS,
  localparam int IDX_W       = $clog2(NUM_ENTRY)
) (
  input  logic                  clk_400mhz,
  input  logic                  rstn,
  input  logic                  query_en,
  input  hot_tracker_pkg::cmd_t  query_cmd,
  input  logic                  mig_credit,
  input  logic                  even_max_valid,
  input  hot_tracker_pkg::page_t even_max_page,
  input  hot_tracker_pkg::cnt_t  even_max_cnt,
  input  logic [IDX_W-1:0]      even_max_idx,
  input  logic                  odd_max_valid,
  input  hot_tracker_pkg::page_t odd_max_page,
  input  hot_tracker_pkg::cnt_t  odd_max_cnt,
  input  logic [IDX_W-1:0]      odd_max_idx,
  output logic                  query_ready,
  output logic                  busy,
  output logic                  even_clr_en,
  output logic                  odd_clr_en,
  output logic [IDX_W-1:0]      clr_idx,
  output logic                  mig_addr_en,
  output hot_tracker_pkg::addr_t mig_addr
);

  import hot_tracker_pkg::*;

  localparam int CRED_W = $clog2(MIG_CREDITS + 1);

  logic              busy_r;    // query in progress
  cmd_t              remain;    // pages still to send
  cmd_t              k_clamped;
  logic [CRED_W-1:0] credits;
  logic              accept;
  logic              any_valid;
  logic              pick_even;
  logic              emit;
  page_t             pick_page;

  assign query_ready = ~busy_r;
  assign busy        = busy_r;
  assign accept      = query_en & query_ready;
  assign k_clamped   = (query_cmd > cmd_t'(TOP_K)) ? cmd_t'(TOP_K) : query_cmd;

  ////////////////////////////////////////////////////////////
  // merge of the two bank candidates
  ////////////////////////////////////////////////////////////

  assign any_valid = even_max_valid | odd_max_valid;
  assign pick_even = even_max_valid & (~odd_max_valid | (even_max_cnt >= odd_max_cnt));
  assign pick_page = pick_even ? even_max_page : odd_max_page;
  assign emit      = busy_r & any_valid & (credits != '0); // no credit, tables untouched

  assign even_clr_en = emit & pick_even;
  assign odd_clr_en  = emit & ~pick_even;
  assign clr_idx     = pick_even ? even_max_idx : odd_max_idx;

  ////////////////////////////////////////////////////////////
  // query control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_400mhz or negedge rstn) begin
    if (!rstn) begin
      busy_r <= 1'b0;
      remain <= '0;
    end else if (accept) begin
      busy_r <= (k_clamped != '0); // zero command ends right away
      remain <= k_clamped;
    end else if (busy_r) begin
      if (!any_valid) begin
        busy_r <= 1'b0;            // both banks drained early
      end else if (emit) begin
        remain <= remain - 1'b1;
        if (remain == cmd_t'(1)) begin
          busy_r <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // credits and migration output
  ////////////////////////////////////////////////////////////

  // spent when the address is launched, returned by the consumer pulse
  always_ff @(posedge clk_400mhz or negedge rstn) begin
    if (!rstn) begin
      credits <= CRED_W'(MIG_CREDITS);
    end else begin
      credits <= credits - CRED_W'(emit) + CRED_W'(mig_credit);
    end
  end

  always_ff @(posedge clk_400mhz or negedge rstn) begin
    if (!rstn) begin
      mig_addr_en <= 1'b0;
    end else begin
      mig_addr_en <= emit;
    end
  end

  always_ff @(posedge clk_400mhz) begin
    if (emit) begin
      mig_addr <= {pick_page, {PAGE_SHIFT{1'b0}}}; // first line of the page
    end
  end

endmodule

/* design/hot_tracker_top.sv */
`timescale 1ns/100ps

module hot_tracker_top #(
  parameter int NUM_ENTRY   = hot_tracker_pkg::DEF_NUM_ENTRY,
  parameter int MIG_CREDITS = hot_tracker_pkg::DEF_MIG_CREDITS
) (
  input  logic                  clk_400mhz,
  input  logic                  rstn,
  input  hot_tracker_pkg::addr_t araddr,
  input  logic                  arvalid,
  input  logic                  arready,
  input  hot_tracker_pkg::addr_t csr_addr_lb,
  input  hot_tracker_pkg::addr_t csr_addr_ub,
  input  logic                  query_en,
  input  hot_tracker_pkg::cmd_t  query_cmd,
  input  logic                  mig_credit,
  output logic                  mem_chan_rd_en,
  output logic                  query_ready,
  output logic                  mig_addr_en,
  output hot_tracker_pkg::addr_t mig_addr
);

  import hot_tracker_pkg::*;

  localparam int IDX_W = $clog2(NUM_ENTRY);

  ////////////////////////////////////////////////////////////
  // filter to banks
  ////////////////////////////////////////////////////////////

  logic             even_hit_en;
  page_t            even_page;
  logic             odd_hit_en;
  page_t            odd_page;

  ////////////////////////////////////////////////////////////
  // banks to selector and back
  ////////////////////////////////////////////////////////////

  logic             even_max_valid;
  page_t            even_max_page;
  cnt_t             even_max_cnt;
  logic [IDX_W-1:0] even_max_idx;
  logic             odd_max_valid;
  page_t            odd_max_page;
  cnt_t             odd_max_cnt;
  logic [IDX_W-1:0] odd_max_idx;
  logic             busy;
  logic             even_clr_en;
  logic             odd_clr_en;
  logic [IDX_W-1:0] clr_idx;

  access_filter u_access_filter (
    .clk_400mhz     (clk_400mhz),
    .rstn           (rstn),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .csr_addr_lb    (csr_addr_lb),
    .csr_addr_ub    (csr_addr_ub),
    .mem_chan_rd_en (mem_chan_rd_en),
    .even_hit_en    (even_hit_en),
    .even_page      (even_page),
    .odd_hit_en     (odd_hit_en),
    .odd_page       (odd_page)
  );

  hot_tracker_bank #(.NUM_ENTRY(NUM_ENTRY)) u_even_bank (
    .clk_400mhz (clk_400mhz),
    .rstn       (rstn),
    .hit_en     (even_hit_en),
    .page       (even_page),
    .busy       (busy),
    .clr_en     (even_clr_en),
    .clr_idx    (clr_idx),
    .max_valid  (even_max_valid),
    .max_page   (even_max_page),
    .max_cnt    (even_max_cnt),
    .max_idx    (even_max_idx)
  );

  hot_tracker_bank #(.NUM_ENTRY(NUM_ENTRY)) u_odd_bank (
    .clk_400mhz (clk_400mhz),
    .rstn       (rstn),
    .hit_en     (odd_hit_en),
    .page       (odd_page),
    .busy       (busy),
    .clr_en     (odd_clr_en),
    .clr_idx    (clr_idx),
    .max_valid  (odd_max_valid),
    .max_page   (odd_max_page),
    .max_cnt    (odd_max_cnt),
    .max_idx    (odd_max_idx)
  );

  mig_addr_selector #(
    .NUM_ENTRY   (NUM_ENTRY),
    .MIG_CREDITS (MIG_CREDITS)
  ) u_mig_addr_selector (
    .clk_400mhz     (clk_400mhz),
    .rstn           (rstn),
    .query_en       (query_en),
    .query_cmd      (query_cmd),
    .mig_credit     (mig_credit),
    .even_max_valid (even_max_valid),
    .even_max_page  (even_max_page),
    .even_max_cnt   (even_max_cnt),
    .even_max_idx   (even_max_idx),
    .odd_max_valid  (odd_max_valid),
    .odd_max_page   (odd_max_page),
    .odd_max_cnt    (odd_max_cnt),
    .odd_max_idx    (odd_max_idx),
    .query_ready    (query_ready),
    .busy           (busy),
    .even_clr_en    (even_clr_en),
    .odd_clr_en     (odd_clr_en),
    .clr_idx        (clr_idx),
    .mig_addr_en    (mig_addr_en),
    .mig_addr       (mig_addr)
  );

endmodule

/* test/hot_tracker_tb.sv */
`timescale 1ns/100ps

module hot_tracker_tb;

  import hot_tracker_pkg::*;

  logic  clk_400mhz;
  logic  rstn;
  addr_t araddr;
  logic  arvalid;
  logic  arready;
  addr_t csr_addr_lb;
  addr_t csr_addr_ub;
  logic  query_en;
  cmd_t  query_cmd;
  logic  mig_credit;
  logic  mem_chan_rd_en;
  logic  query_ready;
  logic  mig_addr_en;
  addr_t mig_addr;

  addr_t       exp_q[$];                      // migration addresses still awaited
  addr_t       lb_model = '0;                 // bounds as the filter holds them
  addr_t       ub_model = '0;
  int          credit_cnt = DEF_MIG_CREDITS;
  int          ret_pending = 0;               // credits owed back to the DUT
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  logic [31:0] rng_state = 32'h55c0_464b;

  hot_tracker_top #(
    .NUM_ENTRY   (DEF_NUM_ENTRY),
    .MIG_CREDITS (DEF_MIG_CREDITS)
  ) DUT (.*);

  initial clk_400mhz = 1'b0;
  always #2 clk_400mhz = ~clk_400mhz; // 4 ns period

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("MISMATCH %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_cycle();
    @(posedge clk_400mhz);
    #0.5; // inputs change just after the edge
  endtask

  ////////////////////////////////////////////////////////////
  // migration monitor, credit return and timeout
  ////////////////////////////////////////////////////////////

  always @(negedge clk_400mhz) begin
    if (rstn && mig_addr_en) begin
      check_value("credit before emission", 64'd1, 64'(credit_cnt > 0));
      credit_cnt--;
      ret_pending++;
      if (exp_q.size() == 0) begin
        abort_run($sformatf("migration address %0h arrived with none expected", mig_addr));
      end else begin
        check_value("migration address", 64'(exp_q.pop_front()), 64'(mig_addr));
      end
    end
  end

  initial begin : credit_return
    int delay;
    mig_credit = 1'b0;
    forever begin
      @(posedge clk_400mhz);
      if (ret_pending > 0) begin
        rng_state = xorshift32(rng_state);
        delay     = int'(rng_state[2:0]); // 0 to 7 cycles
        repeat (delay) @(posedge clk_400mhz);
        #0.5;
        mig_credit = 1'b1;
        ret_pending--;
        @(posedge clk_400mhz);            // DUT samples the pulse here
        #0.5;
        mig_credit = 1'b0;
        @(posedge clk_400mhz);
        credit_cnt++;                     // usable from the emission launched here
      end
    end
  end

  always @(posedge clk_400mhz) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles, the patterns did not finish", cycle_cnt));
    end
  end

  ////////////////////////////////////////////////////////////
  // pattern reader and driver
  ////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    int    n;
    int    n_lines;
    string cmd;
    string line;
    addr_t a;
    addr_t b;
    logic  rdy;
    logic  exp_rd;
    cmd_t  k;

    rstn        = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    arready     = 1'b0;
    csr_addr_lb = '0;
    csr_addr_ub = '0;
    query_en    = 1'b0;
    query_cmd   = '0;
    n_lines     = 0;

    fd = $fopen("test/hot_tracker_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open test/hot_tracker_patterns.txt");
    end
    while ($fgets(line, fd) > 0) begin
      n_lines++;
    end
    $fclose(fd);
    cycle_limit = 64 * n_lines + 100;

    repeat (3) @(posedge clk_400mhz);
    #0.5;
    rstn = 1'b1;
    check_value("reset query_ready", 64'd1, 64'(query_ready));
    check_value("reset mig_addr_en", 64'd0, 64'(mig_addr_en));
    check_value("reset mem_chan_rd_en", 64'd0, 64'(mem_chan_rd_en));

    fd = $fopen("test/hot_tracker_patterns.txt", "r");
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "#") begin
        n = $fgets(line, fd);                   // skip comment text
      end else if (cmd == "B") begin
        n = $fscanf(fd, "%h %h", a, b);
        if (n != 2) begin
          abort_run("pattern file has a B line without two bounds");
        end
        csr_addr_lb = a;
        csr_addr_ub = b;
        next_cycle();
        next_cycle();                           // bound registers loaded
        lb_model = a;
        ub_model = b;
      end else if (cmd == "A") begin
        n = $fscanf(fd, "%h %h", a, rdy);
        if (n != 2) begin
          abort_run("pattern file has an A line without address and arready");
        end
        araddr  = a;
        arvalid = 1'b1;
        arready = rdy;
        exp_rd  = rdy && (a >= lb_model) && (a <= ub_model);
        @(negedge clk_400mhz);
        check_value($sformatf("range filter at %0h", a), 64'(exp_rd), 64'(mem_chan_rd_en));
        next_cycle();
        arvalid = 1'b0;
        arready = 1'b0;
      end else if (cmd == "Q") begin
        n = $fscanf(fd, "%h", k);
        if (n != 1) begin
          abort_run("pattern file has a Q line without a page count");
        end
        while (!query_ready) next_cycle();
        query_en  = 1'b1;
        query_cmd = k;
        next_cycle();
        query_en  = 1'b0;
      end else if (cmd == "E") begin
        n = $fscanf(fd, "%h", a);
        if (n != 1) begin
          abort_run("pattern file has an E line without an address");
        end
        exp_q.push_back(a);
      end else if (cmd == "D") begin
        while (!query_ready) next_cycle();
        next_cycle();
        next_cycle();                           // room for a late extra address
        check_value("addresses missing at query end", 64'd0, 64'(exp_q.size()));
      end else begin
        abort_run({"unknown command in pattern file: ", cmd});
      end
    end
    $fclose(fd);

    if (exp_q.size() != 0) begin
      abort_run("expected migration addresses were never received");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

/* test/hot_tracker_patterns.txt */
# columns: B lb ub | A addr arready | Q k | E expected mig_addr | D end of query
# all values are hex and arvalid is high on every A line
B 000010000 00001ffff
# one below lb, one above ub, arready low
A 00000ffff 1
A 000020000 1
A 000010800 0
# page 21 three hits, pages 20 and 23 two, pages 22 and 3f one
A 000010000 1
A 0000107ff 1
A 000010800 1
A 000010a00 1
A 000010fff 1
A 000011800 1
A 000011900 1
A 000011000 1
A 00001ffff 1
Q 3
E 000010800
E 000010000
E 000011800
D
# two pages left so the query ends early
Q 5
E 000011000
E 00001f800
D
# ten even pages into eight entries so pages 30 and 32 are dropped
A 000010000 1
A 000011000 1
A 000012000 1
A 000013000 1
A 000014000 1
A 000015000 1
A 000016000 1
A 000017000 1
A 000018000 1
A 000019000 1
Q f
E 000010000
E 000011000
E 000012000
E 000013000
E 000014000
D
Q 0
D
Q 5
E 000015000
E 000016000
E 000017000
D

/* vlog.f */
design/hot_tracker_pkg.sv
design/access_filter.sv
design/hot_tracker_bank.sv
design/mig_addr_selector.sv
design/hot_tracker_top.sv
test/hot_tracker_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the hot-page tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module hot_tracker_tb -Mdir obj_dir -f vlog.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/Vhot_tracker_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi
exit 0
